// ==== hdl/uart_defs.svh ====
// ------------------------------
// UART peripheral definitions
// FIFO depth, register map, CR/SR bit fields
// ------------------------------
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

`define UART_FIFO_DEPTH 4

`define UART_ADDR_DR  32'h0000_0000
`define UART_ADDR_CR  32'h0000_0004
`define UART_ADDR_SR  32'h0000_0008
`define UART_ADDR_BRR 32'h0000_000C
`define UART_ADDR_IER 32'h0000_0010

// Control register fields
`define UART_CR_PE    0
`define UART_CR_TXE   1
`define UART_CR_RXE   2
`define UART_CR_PEN   3
`define UART_CR_ODD   4
`define UART_CR_STOP2 5

// Status fields, IER uses the same positions
`define UART_SR_TBE  0
`define UART_SR_RBF  1
`define UART_SR_PERR 2
`define UART_SR_OVR  3

`define UART_BRR_RESET 16'd16

`endif

// ==== hdl/uart_pkg.sv ====
// ------------------------------
// UART peripheral types
// FIFO payloads and parity mode
// ------------------------------
`default_nettype none

package uart_pkg;

    // One data byte, TX FIFO payload
    typedef logic [7:0] uart_byte_t;

    // Received byte with its parity check result
    typedef struct packed {
        logic       perr;
        uart_byte_t data;
    } uart_rx_frame_t;

    typedef enum logic [1:0] {
        UART_PARITY_NONE,
        UART_PARITY_EVEN,
        UART_PARITY_ODD
    } uart_parity_e;

endpackage

`default_nettype wire

// ==== hdl/uart_fifo.sv ====
// ------------------------------
// UART FIFO stage
// Circular buffer, one credit pulse per pop
// ------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "uart_defs.svh"

module uart_fifo #(
    parameter type         payload_t = logic [7:0],
    parameter int unsigned DEPTH     = `UART_FIFO_DEPTH
) (
    input  logic     seq,
    input  logic     rst_n,
    input  logic     in_valid,
    input  payload_t in_data,
    input  logic     out_pop,
    output logic     credit,
    output logic     out_valid,
    output payload_t out_data
);

    localparam int unsigned PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CW = $clog2(DEPTH + 1);

    payload_t        mem [DEPTH];
    logic [PW-1:0]   wr_ptr;
    logic [PW-1:0]   rd_ptr;
    logic [CW-1:0]   count;

    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    always_ff @(posedge seq) begin
        if (in_valid) mem[wr_ptr] <= in_data; // Sender holds a credit
    end

    always_ff @(posedge seq or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            credit <= out_pop;
            if (in_valid)
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (out_pop)
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (in_valid && !out_pop)
                count <= count + 1'b1;
            else if (out_pop && !in_valid)
                count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/uart_tx.sv ====
// ------------------------------
// UART serializer
// Pops TX FIFO, shifts frames out LSB first
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module uart_tx import uart_pkg::*; (
    input  logic         seq,
    input  logic         rst_n,
    input  logic         enable,
    input  logic [15:0]  brr,
    input  uart_parity_e parity,
    input  logic         stop2,
    input  logic         out_valid,
    input  uart_byte_t   out_data,
    output logic         out_pop,
    output logic         tx
);

    typedef enum logic [2:0] {IDLE, START, DATA, PARITY, STOP} state_e;

    state_e     state;
    logic [15:0] baud_cnt;
    logic [2:0]  bit_cnt;
    uart_byte_t  shift;
    logic        par_bit;
    logic        bit_end;

    assign bit_end = (baud_cnt == brr - 16'd1);
    assign out_pop = (state == IDLE) && enable && out_valid;

    always_ff @(posedge seq or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            tx       <= 1'b1; // Line idles high
        end else if (state == IDLE) begin
            baud_cnt <= '0;
            if (out_pop) begin
                state <= START;
                tx    <= 1'b0;
            end
        end else if (!bit_end) begin
            baud_cnt <= baud_cnt + 16'd1;
        end else begin
            baud_cnt <= '0;
            case (state)
                START: begin
                    state   <= DATA;
                    bit_cnt <= '0;
                    tx      <= shift[0];
                end
                DATA: begin
                    bit_cnt <= bit_cnt + 3'd1;
                    tx      <= shift[1];
                    if (bit_cnt == 3'd7) begin
                        bit_cnt <= '0;
                        state   <= (parity == UART_PARITY_NONE) ? STOP : PARITY;
                        tx      <= (parity == UART_PARITY_NONE) ? 1'b1 : par_bit;
                    end
                end
                PARITY: begin
                    state <= STOP;
                    tx    <= 1'b1;
                end
                default: begin
                    if (stop2 && bit_cnt == 3'd0) bit_cnt <= 3'd1; // Second stop bit
                    else state <= IDLE;
                end
            endcase
        end
    end

    // Payload, loaded on pop
    always_ff @(posedge seq) begin
        if (out_pop) begin
            shift   <= out_data;
            par_bit <= ^out_data ^ (parity == UART_PARITY_ODD);
        end else if (state == DATA && bit_end) begin
            shift <= shift >> 1;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/uart_rx.sv ====
// ------------------------------
// UART deserializer
// Mid-bit sampling, parity check, RX credits
// ------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "uart_defs.svh"

module uart_rx import uart_pkg::*; (
    input  logic           seq,
    input  logic           rst_n,
    input  logic           enable,
    input  logic [15:0]    brr,
    input  uart_parity_e   parity,
    input  logic           credit,
    input  logic           rx,
    output logic           in_valid,
    output uart_rx_frame_t in_data,
    output logic           overrun
);

    localparam int unsigned CW = $clog2(`UART_FIFO_DEPTH + 1);
    localparam logic [CW-1:0] FULL_CREDIT = CW'(`UART_FIFO_DEPTH);

    typedef enum logic [2:0] {IDLE, START, DATA, PARITY, STOP} state_e;

    state_e      state;
    logic        rx_meta;
    logic        rx_sync;
    logic        rx_prev;
    logic [15:0] baud_cnt;
    logic [2:0]  bit_cnt;
    uart_byte_t  shift;
    logic        par_acc;
    logic        perr;
    logic [CW-1:0] credits;
    logic        half_end;
    logic        bit_end;
    logic        frame_done;

    assign half_end   = (baud_cnt == {1'b0, brr[15:1]} - 16'd1);
    assign bit_end    = (baud_cnt == brr - 16'd1);
    assign frame_done = (state == STOP) && bit_end;

    // Two-flop synchronizer plus edge history
    always_ff @(posedge seq or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge seq or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (!enable) begin
            state <= IDLE;
        end else if (state == IDLE) begin
            baud_cnt <= '0;
            if (rx_prev && !rx_sync) state <= START; // Falling edge
        end else if (state == START) begin
            baud_cnt <= baud_cnt + 16'd1;
            if (half_end) begin
                baud_cnt <= '0;
                bit_cnt  <= '0;
                state    <= rx_sync ? IDLE : DATA; // Glitch rejected
            end
        end else if (!bit_end) begin
            baud_cnt <= baud_cnt + 16'd1;
        end else begin
            baud_cnt <= '0;
            case (state)
                DATA: begin
                    bit_cnt <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'd7)
                        state <= (parity == UART_PARITY_NONE) ? STOP : PARITY;
                end
                PARITY:  state <= STOP;
                default: state <= IDLE; // Middle of first stop bit
            endcase
        end
    end

    always_ff @(posedge seq) begin
        if (state == START) begin
            par_acc <= 1'b0;
            perr    <= 1'b0;
        end else if (state == DATA && bit_end) begin
            shift   <= {rx_sync, shift[7:1]};
            par_acc <= par_acc ^ rx_sync;
        end else if (state == PARITY && bit_end) begin
            perr <= rx_sync ^ par_acc ^ (parity == UART_PARITY_ODD);
        end
        if (frame_done) in_data <= '{perr: perr, data: shift};
    end

    // Push with a credit, otherwise drop and flag
    always_ff @(posedge seq or negedge rst_n) begin
        if (!rst_n) begin
            in_valid <= 1'b0;
            overrun  <= 1'b0;
            credits  <= FULL_CREDIT;
        end else begin
            in_valid <= frame_done && (credits != '0);
            overrun  <= frame_done && (credits == '0);
            if (in_valid && !credit) credits <= credits - 1'b1;
            else if (credit && !in_valid) credits <= credits + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/uart_regs.sv ====
// ------------------------------
// UART register block
// APB decode, TX credits, status and irq
// ------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "uart_defs.svh"

module uart_regs import uart_pkg::*; (
    input  logic           seq,
    input  logic           rst_n,
    input  logic [31:0]    paddr,
    input  logic           psel,
    input  logic           penable,
    input  logic           pwrite,
    input  logic [31:0]    pwdata,
    output logic [31:0]    prdata,
    output logic           pslverr,
    output logic           irq,
    output logic           tx_enable,
    output logic           rx_enable,
    output uart_parity_e   parity,
    output logic           stop2,
    output logic [15:0]    brr,
    input  logic           tx_credit,
    output logic           tx_valid,
    output uart_byte_t     tx_data,
    input  logic           rx_valid,
    input  uart_rx_frame_t rx_data,
    output logic           rx_pop,
    input  logic           rx_overrun
);

    localparam int unsigned CW = $clog2(`UART_FIFO_DEPTH + 1);
    localparam logic [CW-1:0] FULL_CREDIT = CW'(`UART_FIFO_DEPTH);

    logic [5:0]    cr;
    logic [3:0]    ier;
    logic [3:0]    sr;
    logic          ovr;
    logic [CW-1:0] tx_credits;
    logic          access;
    logic          wr;
    logic          rd;
    logic          dr_sel;
    logic          pe;

    assign access = psel && penable;
    assign wr     = access && pwrite;
    assign rd     = access && !pwrite;
    assign dr_sel = (paddr == `UART_ADDR_DR);
    assign pe     = cr[`UART_CR_PE];

    assign pslverr  = access && dr_sel && !pe; // DR locked while disabled
    assign tx_valid = wr && dr_sel && pe && (tx_credits != '0);
    assign tx_data  = pwdata[7:0];
    assign rx_pop   = rd && dr_sel && pe && rx_valid;

    assign tx_enable = pe && cr[`UART_CR_TXE];
    assign rx_enable = pe && cr[`UART_CR_RXE];
    assign stop2     = cr[`UART_CR_STOP2];
    assign parity    = !cr[`UART_CR_PEN] ? UART_PARITY_NONE :
                       cr[`UART_CR_ODD]  ? UART_PARITY_ODD  : UART_PARITY_EVEN;

    always_comb begin
        sr                = '0;
        sr[`UART_SR_TBE]  = (tx_credits != '0);
        sr[`UART_SR_RBF]  = rx_valid;
        sr[`UART_SR_PERR] = rx_valid && rx_data.perr; // Head entry only
        sr[`UART_SR_OVR]  = ovr;
    end

    assign irq = |(sr & ier);

    always_comb begin
        case (paddr)
            `UART_ADDR_DR:  prdata = rx_pop ? {24'd0, rx_data.data} : '0;
            `UART_ADDR_CR:  prdata = {26'd0, cr};
            `UART_ADDR_SR:  prdata = {28'd0, sr};
            `UART_ADDR_BRR: prdata = {16'd0, brr};
            `UART_ADDR_IER: prdata = {28'd0, ier};
            default:        prdata = '0;
        endcase
    end

    always_ff @(posedge seq or negedge rst_n) begin
        if (!rst_n) begin
            cr  <= '0;
            ier <= '0;
            brr <= `UART_BRR_RESET;
            ovr <= 1'b0;
        end else begin
            if (wr && paddr == `UART_ADDR_CR)  cr  <= pwdata[5:0];
            if (wr && paddr == `UART_ADDR_BRR) brr <= pwdata[15:0];
            if (wr && paddr == `UART_ADDR_IER) ier <= pwdata[3:0];
            if (rx_overrun)
                ovr <= 1'b1; // New overrun wins over the clearing read
            else if (rd && paddr == `UART_ADDR_SR)
                ovr <= 1'b0;
        end
    end

    // Credits into the TX FIFO
    always_ff @(posedge seq or negedge rst_n) begin
        if (!rst_n)
            tx_credits <= FULL_CREDIT;
        else if (tx_valid && !tx_credit)
            tx_credits <= tx_credits - 1'b1;
        else if (tx_credit && !tx_valid)
            tx_credits <= tx_credits + 1'b1;
    end

endmodule

`default_nettype wire

// ==== hdl/uart_periph.sv ====
// ------------------------------
// UART peripheral top
// APB registers, FIFOs, TX and RX stages
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module uart_periph import uart_pkg::*; (
    input  logic        seq,
    input  logic        rst_n,
    input  logic [31:0] paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pslverr,
    output logic        irq,
    output logic        tx,
    input  logic        rx
);

    logic           tx_enable;
    logic           rx_enable;
    uart_parity_e   parity;
    logic           stop2;
    logic [15:0]    brr;

    // TX path
    logic           tx_in_valid;
    uart_byte_t     tx_in_data;
    logic           tx_credit;
    logic           tx_out_valid;
    uart_byte_t     tx_out_data;
    logic           tx_pop;

    // RX path
    logic           rx_in_valid;
    uart_rx_frame_t rx_in_data;
    logic           rx_credit;
    logic           rx_out_valid;
    uart_rx_frame_t rx_out_data;
    logic           rx_pop;
    logic           rx_overrun;

    uart_regs i_uart_regs (
        .seq        (seq),
        .rst_n      (rst_n),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pslverr    (pslverr),
        .irq        (irq),
        .tx_enable  (tx_enable),
        .rx_enable  (rx_enable),
        .parity     (parity),
        .stop2      (stop2),
        .brr        (brr),
        .tx_credit  (tx_credit),
        .tx_valid   (tx_in_valid),
        .tx_data    (tx_in_data),
        .rx_valid   (rx_out_valid),
        .rx_data    (rx_out_data),
        .rx_pop     (rx_pop),
        .rx_overrun (rx_overrun)
    );

    uart_fifo #(.payload_t(uart_byte_t)) i_tx_fifo (
        .seq       (seq),
        .rst_n     (rst_n),
        .in_valid  (tx_in_valid),
        .in_data   (tx_in_data),
        .out_pop   (tx_pop),
        .credit    (tx_credit),
        .out_valid (tx_out_valid),
        .out_data  (tx_out_data)
    );

    uart_tx i_uart_tx (
        .seq       (seq),
        .rst_n     (rst_n),
        .enable    (tx_enable),
        .brr       (brr),
        .parity    (parity),
        .stop2     (stop2),
        .out_valid (tx_out_valid),
        .out_data  (tx_out_data),
        .out_pop   (tx_pop),
        .tx        (tx)
    );

    uart_rx i_uart_rx (
        .seq      (seq),
        .rst_n    (rst_n),
        .enable   (rx_enable),
        .brr      (brr),
        .parity   (parity),
        .credit   (rx_credit),
        .rx       (rx),
        .in_valid (rx_in_valid),
        .in_data  (rx_in_data),
        .overrun  (rx_overrun)
    );

    uart_fifo #(.payload_t(uart_rx_frame_t)) i_rx_fifo (
        .seq       (seq),
        .rst_n     (rst_n),
        .in_valid  (rx_in_valid),
        .in_data   (rx_in_data),
        .out_pop   (rx_pop),
        .credit    (rx_credit),
        .out_valid (rx_out_valid),
        .out_data  (rx_out_data)
    );

endmodule

`default_nettype wire

// ==== test/uart_periph_tb.sv ====
// ------------------------------
// UART peripheral testbench
// Directed APB tests, loopback and bit-banged RX
// ------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "uart_defs.svh"

module uart_periph_tb;

    localparam int BIT_CYCLES    = 8;                 // BRR used by the tests
    localparam int IDLE_CYCLES   = 12 * BIT_CYCLES;   // Longer than any high run in a frame
    localparam int SR_POLL_LIMIT = 500;
    localparam int WAIT_LIMIT    = 4000;
    localparam logic [31:0] CR_ON = (32'd1 << `UART_CR_PE) | (32'd1 << `UART_CR_TXE) |
                                    (32'd1 << `UART_CR_RXE);
    localparam logic [31:0] SR_TBE  = 32'd1 << `UART_SR_TBE;
    localparam logic [31:0] SR_RBF  = 32'd1 << `UART_SR_RBF;
    localparam logic [31:0] SR_PERR = 32'd1 << `UART_SR_PERR;
    localparam logic [31:0] SR_OVR  = 32'd1 << `UART_SR_OVR;

    logic        seq;
    logic        rst_n;
    logic [31:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pslverr;
    logic        irq;
    logic        tx;
    logic        rx_line;
    logic        bb_rx;     // Bit-banged line
    logic        loopback;

    logic [31:0] lfsr_state;
    int          check_count;
    int          mismatch_count;
    int          fail_count;

    assign rx_line = loopback ? tx : bb_rx;

    uart_periph i_uart_periph (
        .seq     (seq),
        .rst_n   (rst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pslverr (pslverr),
        .irq     (irq),
        .tx      (tx),
        .rx      (rx_line)
    );

    initial begin
        seq = 1'b0;
        forever #10 seq = ~seq;
    end

    // Taps 32, 22, 2, 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [7:0] lfsr_byte();
        logic [7:0] b;
        for (int i = 0; i < 8; i++) b[i] = lfsr_step();
        return b;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
            mismatch_count++;
        end
    endtask

    // Setup cycle, then access cycle sampled mid-cycle
    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data,
                             output logic err);
        @(negedge seq);
        paddr   = addr;
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge seq);
        penable = 1'b1;
        #5;
        err = pslverr;
        @(negedge seq);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [31:0] addr, output logic [31:0] data,
                            output logic err);
        @(negedge seq);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge seq);
        penable = 1'b1;
        #5;
        data = prdata;
        err  = pslverr;
        @(negedge seq);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic wait_sr_bit(input int bit_idx, input string name);
        logic [31:0] rdata;
        logic        err;
        int          polls;
        polls = 0;
        apb_read(`UART_ADDR_SR, rdata, err);
        while (!rdata[bit_idx] && polls < SR_POLL_LIMIT) begin
            polls++;
            apb_read(`UART_ADDR_SR, rdata, err);
        end
        if (!rdata[bit_idx]) begin
            $display("Timeout: status bit %s never went high", name);
            fail_count++;
        end
    endtask

    // Line counts as idle once it stays high longer than any frame can
    task automatic wait_line_idle();
        int high_run;
        int cycles;
        high_run = 0;
        cycles   = 0;
        while (high_run < IDLE_CYCLES && cycles < WAIT_LIMIT) begin
            @(negedge seq);
            cycles++;
            high_run = tx ? high_run + 1 : 0;
        end
        if (high_run < IDLE_CYCLES) begin
            $display("Timeout: serial line never went idle");
            fail_count++;
        end
    endtask

    task automatic wait_irq_high();
        int cycles;
        cycles = 0;
        while (!irq && cycles < WAIT_LIMIT) begin
            @(negedge seq);
            cycles++;
        end
        if (!irq) begin
            $display("Timeout: irq never went high");
            fail_count++;
        end
    endtask

    // Even parity frame with one stop bit
    task automatic send_serial_frame(input logic [7:0] data, input logic bad_parity);
        logic [10:0] bits;
        bits = {1'b1, (^data) ^ bad_parity, data, 1'b0};
        for (int i = 0; i < 11; i++) begin
            @(negedge seq);
            bb_rx = bits[i];
            repeat (BIT_CYCLES - 1) @(negedge seq);
        end
    endtask

    task automatic reset_and_readback();
        logic [31:0] rdata;
        logic        err;
        check("irq", irq, 0);
        check("tx", tx, 1);
        apb_read(`UART_ADDR_CR, rdata, err);
        check("CR", rdata, 0);
        apb_read(`UART_ADDR_IER, rdata, err);
        check("IER", rdata, 0);
        apb_read(`UART_ADDR_BRR, rdata, err);
        check("BRR", rdata, 16);
        apb_write(`UART_ADDR_BRR, BIT_CYCLES, err);
        check("pslverr", err, 0);
        apb_read(`UART_ADDR_BRR, rdata, err);
        check("BRR", rdata, BIT_CYCLES);
        apb_write(`UART_ADDR_CR, 32'h3e, err); // Everything but PE
        check("pslverr", err, 0);
        apb_read(`UART_ADDR_CR, rdata, err);
        check("CR", rdata, 32'h3e);
        check("pslverr", err, 0);
        apb_write(`UART_ADDR_IER, 32'ha, err);
        check("pslverr", err, 0);
        apb_read(`UART_ADDR_IER, rdata, err);
        check("IER", rdata, 32'ha);
        check("pslverr", err, 0);
        apb_write(`UART_ADDR_IER, 0, err);
        apb_write(`UART_ADDR_CR, 0, err);
    endtask

    task automatic disabled_access();
        logic [31:0] rdata;
        logic        err;
        apb_read(`UART_ADDR_DR, rdata, err);
        check("pslverr", err, 1);
        check("DR", rdata, 0);
        apb_write(`UART_ADDR_DR, 32'h55, err);
        check("pslverr", err, 1);
        apb_write(`UART_ADDR_CR, CR_ON, err);
        apb_read(`UART_ADDR_SR, rdata, err);
        check("SR", rdata, SR_TBE);
        check("tx", tx, 1);
    endtask

    task automatic loopback_run(input logic [31:0] cr_val, input int count);
        logic [7:0]  sent [$];
        logic [7:0]  b;
        logic [31:0] rdata;
        logic        err;
        apb_write(`UART_ADDR_CR, cr_val, err);
        for (int i = 0; i < count; i++) begin
            wait_sr_bit(`UART_SR_TBE, "TBE");
            b = lfsr_byte();
            apb_write(`UART_ADDR_DR, {24'd0, b}, err);
            sent.push_back(b);
        end
        for (int i = 0; i < count; i++) begin
            wait_sr_bit(`UART_SR_RBF, "RBF");
            apb_read(`UART_ADDR_SR, rdata, err);
            check("SR.PERR", rdata[`UART_SR_PERR], 0);
            apb_read(`UART_ADDR_DR, rdata, err);
            check("DR", rdata, {24'd0, sent[i]});
        end
        wait_line_idle();
    endtask

    task automatic credit_overrun();
        logic [7:0]  sent [$];
        logic [7:0]  b;
        logic [31:0] rdata;
        logic        err;
        apb_write(`UART_ADDR_CR, CR_ON, err);
        apb_read(`UART_ADDR_SR, rdata, err); // Start with OVR clear
        for (int i = 0; i < `UART_FIFO_DEPTH + 2; i++) begin
            wait_sr_bit(`UART_SR_TBE, "TBE");
            b = lfsr_byte();
            apb_write(`UART_ADDR_DR, {24'd0, b}, err);
            sent.push_back(b);
        end
        wait_line_idle();
        apb_read(`UART_ADDR_SR, rdata, err);
        check("SR", rdata, SR_TBE | SR_RBF | SR_OVR);
        for (int i = 0; i < `UART_FIFO_DEPTH; i++) begin
            apb_read(`UART_ADDR_DR, rdata, err);
            check("DR", rdata, {24'd0, sent[i]});
        end
        apb_read(`UART_ADDR_SR, rdata, err);
        check("SR", rdata, SR_TBE);
    endtask

    task automatic parity_error_inject();
        logic [31:0] rdata;
        logic        err;
        logic [7:0]  b;
        @(negedge seq);
        loopback = 1'b0;
        apb_write(`UART_ADDR_CR, CR_ON | (32'd1 << `UART_CR_PEN), err);
        b = lfsr_byte();
        send_serial_frame(b, 1'b1);
        wait_sr_bit(`UART_SR_RBF, "RBF");
        apb_read(`UART_ADDR_SR, rdata, err);
        check("SR", rdata, SR_TBE | SR_RBF | SR_PERR);
        apb_read(`UART_ADDR_DR, rdata, err);
        check("DR", rdata, {24'd0, b});
        b = lfsr_byte();
        send_serial_frame(b, 1'b0);
        wait_sr_bit(`UART_SR_RBF, "RBF");
        apb_read(`UART_ADDR_SR, rdata, err);
        check("SR", rdata, SR_TBE | SR_RBF);
        apb_read(`UART_ADDR_DR, rdata, err);
        check("DR", rdata, {24'd0, b});
        @(negedge seq);
        loopback = 1'b1;
    endtask

    task automatic interrupt_masks();
        logic [31:0] rdata;
        logic        err;
        logic [7:0]  b;
        apb_write(`UART_ADDR_CR, CR_ON, err);
        apb_write(`UART_ADDR_IER, SR_TBE, err);
        check("irq", irq, 1);
        apb_write(`UART_ADDR_IER, SR_RBF, err);
        check("irq", irq, 0);
        b = lfsr_byte();
        apb_write(`UART_ADDR_DR, {24'd0, b}, err);
        check("irq", irq, 0); // Frame still on the line
        wait_irq_high();
        apb_read(`UART_ADDR_DR, rdata, err);
        check("DR", rdata, {24'd0, b});
        check("irq", irq, 0);
        wait_line_idle();
    endtask

    initial begin
        rst_n          = 1'b0;
        paddr          = '0;
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        pwdata         = '0;
        bb_rx          = 1'b1;
        loopback       = 1'b1;
        lfsr_state     = 32'h0acfe9ab;
        check_count    = 0;
        mismatch_count = 0;
        fail_count     = 0;
        repeat (4) @(posedge seq);
        @(negedge seq);
        rst_n = 1'b1;

        reset_and_readback();
        disabled_access();
        loopback_run(CR_ON, 3);
        loopback_run(CR_ON | (32'd1 << `UART_CR_PEN), 3);
        loopback_run(CR_ON | (32'd1 << `UART_CR_PEN) | (32'd1 << `UART_CR_ODD) |
                     (32'd1 << `UART_CR_STOP2), 3);
        credit_overrun();
        parity_error_inject();
        interrupt_masks();

        $display("Checks: %0d, mismatches: %0d, other failures: %0d",
                 check_count, mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+hdl
hdl/uart_pkg.sv
hdl/uart_fifo.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_regs.sv
hdl/uart_periph.sv
test/uart_periph_tb.sv

// ==== Bender.yml ====
package:
  name: uart_periph

export_include_dirs:
  - hdl

sources:
  - hdl/uart_pkg.sv
  - hdl/uart_fifo.sv
  - hdl/uart_tx.sv
  - hdl/uart_rx.sv
  - hdl/uart_regs.sv
  - hdl/uart_periph.sv
  - target: test
    files:
      - test/uart_periph_tb.sv
